//--- src.f
verilog/inc_pkg.sv
verilog/credit_fifo.sv
verilog/inc_lookahead.sv
verilog/inc_lane.sv
verilog/inc_dispatch.sv
verilog/inc_collect.sv
verilog/inc_cluster.sv
testbench/inc_cluster_asserts.sv
testbench/inc_cluster_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the INC cluster testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f src.f --top-module inc_cluster_tb

# A nonzero exit of the simulation stops the script here
out=$(./obj_dir/Vinc_cluster_tb 2>&1)
echo "$out"

# Pass only when the pass message is present
echo "$out" | grep -q "^Simulation completed successfully$"

//--- testbench/inc_cluster_tb.sv
/*
  Testbench for the INC cluster
  Operands, carry inputs and sink credit timing come from a Galois LFSR
  Expected results come from a reference model of the INC flag rules
  The run ends at a cycle limit derived from the number of operations
*/
module inc_cluster_tb
	import inc_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	// Operations per test and the sink hold stretch
	localparam int n_corner = 12;
	localparam int n_random = 200;
	localparam int n_press = 40;
	localparam int hold_cycles = 60;
	localparam int cycle_limit = 10 * (n_corner + n_random + n_press) + 200;

	logic clk = 1'b0;
	logic reset;
	logic in_valid;
	inc_op_t in_op;
	logic in_credit;
	logic out_credit;
	logic out_valid;
	inc_res_t out_res;

	// Directed corner operands
	logic [data_w-1:0] corner [6] = '{32'h0000_0000, 32'h0000_000F, 32'h0000_00FF,
		32'h7FFF_FFFF, 32'h8000_0000, 32'hFFFF_FFFF};

	logic [31:0] lfsr_state = 32'd33;
	logic [tag_w-1:0] next_tag;
	inc_res_t exp_q [$];

	// Main process counters
	int accepted;
	int granted;
	int hold_left;
	bit sink_random;
	int main_checks;
	int main_errors;
	int tests;
	int test_checks0;
	int test_errors0;

	// Monitor counters
	int received;
	int credit_pulses;
	int mon_checks;
	int mon_errors;

	int cycles;

	inc_cluster dut_i (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_op(in_op),
		.in_credit(in_credit),
		.out_credit(out_credit),
		.out_valid(out_valid),
		.out_res(out_res)
	);

	// 100 ns period
	always #50 clk = ~clk;

	// ----------------------------------------
	// Random bits and reference model
	// ----------------------------------------
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
		begin
			return (s >> 1) ^ 32'h8020_0003;
		end
		return s >> 1;
	endfunction

	// One LFSR step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
		return v;
	endfunction

	function automatic inc_res_t ref_inc(input inc_op_t op);
		inc_res_t r;
		int ones;
		r.tag = op.tag;
		r.sum = op.a + data_w'(1);
		r.carry_out = (op.a == {data_w{1'b1}});
		r.flags.of = (op.a == 32'h7FFF_FFFF);
		r.flags.sf = r.sum[data_w-1];
		r.flags.zf = (r.sum == '0);
		r.flags.af = (op.a[3:0] == 4'hF);
		// Parity counts ones in the low byte of the sum
		ones = 0;
		for (int i = 0; i < 8; i++)
		begin
			if (r.sum[i])
			begin
				ones++;
			end
		end
		r.flags.pf = (ones % 2 == 0);
		r.flags.cf = op.cf_in;
		return r;
	endfunction

	function automatic int input_credits();
		return in_depth + credit_pulses - accepted;
	endfunction

	function automatic int total_checks();
		return main_checks + mon_checks;
	endfunction

	function automatic int total_errors();
		return main_errors + mon_errors;
	endfunction

	// ----------------------------------------
	// Compare tasks
	// ----------------------------------------
	task automatic check_flags(input inc_flags_t exp, input inc_flags_t act);
		if (act !== exp)
		begin
			$display("FAIL out_res.flags exp=%h got=%h", exp, act);
			mon_errors++;
		end
	endtask

	task automatic check_res(input inc_res_t exp, input inc_res_t act);
		mon_checks++;
		if (act.tag !== exp.tag)
		begin
			$display("FAIL out_res.tag exp=%h got=%h", exp.tag, act.tag);
			mon_errors++;
		end
		if (act.sum !== exp.sum)
		begin
			$display("FAIL out_res.sum exp=%h got=%h", exp.sum, act.sum);
			mon_errors++;
		end
		if (act.carry_out !== exp.carry_out)
		begin
			$display("FAIL out_res.carry_out exp=%h got=%h", exp.carry_out, act.carry_out);
			mon_errors++;
		end
		check_flags(exp.flags, act.flags);
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		main_checks++;
		if (act !== exp)
		begin
			$display("FAIL %s exp=%h got=%h", name, exp, act);
			main_errors++;
		end
	endtask

	// ----------------------------------------
	// Drive tasks
	// ----------------------------------------

	// Advance one cycle, clear the input strobe and run the credit sink
	task automatic next_cycle();
		@(posedge clk);
		#1;
		in_valid = 1'b0;
		out_credit = 1'b0;
		if (hold_left > 0)
		begin
			hold_left--;
		end
		else if (received - granted > 0)
		begin
			// Random release on about half the cycles
			if (!sink_random || rand_bits(1) != '0)
			begin
				out_credit = 1'b1;
				granted++;
			end
		end
	endtask

	// Wait for an input credit, then issue one operation
	task automatic send_op(input logic [data_w-1:0] a, input logic cf);
		inc_op_t op;
		next_cycle();
		while (input_credits() == 0)
		begin
			next_cycle();
		end
		op.tag = next_tag;
		op.a = a;
		op.cf_in = cf;
		next_tag = next_tag + tag_w'(1);
		in_valid = 1'b1;
		in_op = op;
		accepted++;
		exp_q.push_back(ref_inc(op));
	endtask

	task automatic wait_drain();
		next_cycle();
		while (exp_q.size() != 0)
		begin
			next_cycle();
		end
		repeat (4) next_cycle();
	endtask

	task automatic start_test();
		test_checks0 = total_checks();
		test_errors0 = total_errors();
	endtask

	task automatic end_test(input string name);
		$display("test %-12s checks=%0d errors=%0d", name,
			total_checks() - test_checks0, total_errors() - test_errors0);
		tests++;
	endtask

	// ----------------------------------------
	// Output monitor
	// ----------------------------------------
	always @(negedge clk)
	begin : monitor
		inc_res_t exp;
		if (!reset)
		begin
			if (in_credit)
			begin
				credit_pulses++;
				if (input_credits() > in_depth)
				begin
					$display("Input credit count rose above the queue depth");
					mon_errors++;
				end
			end
			if (out_valid)
			begin
				received++;
				if (received > out_credits + granted)
				begin
					$display("out_valid beyond the downstream credits granted");
					mon_errors++;
				end
				if (exp_q.size() == 0)
				begin
					$display("out_valid with no operation outstanding, result duplicated");
					mon_errors++;
				end
				else
				begin
					exp = exp_q.pop_front();
					check_res(exp, out_res);
				end
			end
		end
	end

	// Cycle limit
	always @(posedge clk)
	begin
		cycles++;
		if (cycles > cycle_limit)
		begin
			$display("Timeout after %0d cycles, %0d of %0d results received",
				cycles, received, accepted);
			$display("Simulation failed");
			$finish;
		end
	end

	// ----------------------------------------
	// Test sequence
	// ----------------------------------------
	initial
	begin
		logic [data_w-1:0] rnd_a;
		logic [31:0] rnd_cf;
		reset = 1'b1;
		in_valid = 1'b0;
		in_op = '0;
		out_credit = 1'b0;
		next_tag = '0;

		// Reset state is held for four edges
		start_test();
		repeat (3)
		begin
			@(negedge clk);
			check_bit("out_valid", 1'b0, out_valid);
			check_bit("in_credit", 1'b0, in_credit);
		end
		@(posedge clk);
		#1;
		reset = 1'b0;
		repeat (3)
		begin
			next_cycle();
			@(negedge clk);
			check_bit("out_valid", 1'b0, out_valid);
			check_bit("in_credit", 1'b0, in_credit);
		end
		end_test("reset");

		// Corner operands at full rate with both carry inputs
		start_test();
		for (int i = 0; i < 6; i++)
		begin
			send_op(corner[i], 1'b0);
			send_op(corner[i], 1'b1);
		end
		wait_drain();
		end_test("corner");

		start_test();
		for (int i = 0; i < n_random; i++)
		begin
			rnd_a = rand_bits(data_w);
			rnd_cf = rand_bits(1);
			send_op(rnd_a, rnd_cf[0]);
		end
		wait_drain();
		end_test("random");

		// Sink holds credits, then returns them at random
		start_test();
		hold_left = hold_cycles;
		sink_random = 1'b1;
		for (int i = 0; i < n_press; i++)
		begin
			rnd_a = rand_bits(data_w);
			rnd_cf = rand_bits(1);
			send_op(rnd_a, rnd_cf[0]);
		end
		wait_drain();
		sink_random = 1'b0;
		end_test("backpressure");

		start_test();
		main_checks++;
		if (credit_pulses != accepted)
		begin
			$display("in_credit pulses %0d do not match %0d accepted operations",
				credit_pulses, accepted);
			main_errors++;
		end
		main_checks++;
		if (input_credits() != in_depth || received != accepted)
		begin
			$display("Credits or results unbalanced at the end, %0d credits, %0d of %0d results",
				input_credits(), received, accepted);
			main_errors++;
		end
		end_test("credits");

		$display("tests=%0d checks=%0d errors=%0d", tests, total_checks(), total_errors());
		if (total_errors() == 0)
		begin
			$display("Simulation completed successfully");
		end
		else
		begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- testbench/inc_cluster_asserts.sv
/*
  Credit rule checks for the INC cluster, bound to the top level
  Occupancy is modeled from the handshake wires, not read from the queues
  Lane occupancy counts the operation register and the result queue together
*/
module inc_cluster_asserts
	import inc_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic in_valid,
	input logic in_pop,
	input logic out_valid,
	input logic out_credit,
	input logic [num_lanes-1:0] lane_valid,
	input logic [num_lanes-1:0] lane_pop
);
	timeunit 1ns;
	timeprecision 100ps;

	// Modeled occupancy and downstream credits
	int in_occ;
	int out_avail;
	int lane_out [num_lanes];
	logic [num_lanes-1:0] lane_full;

	// Reset seen at the previous edge
	logic reset_q = 1'b0;

	// ----------------------------------------
	// Occupancy model
	// ----------------------------------------
	always @(posedge clk)
	begin
		reset_q <= reset;
		if (reset)
		begin
			in_occ <= 0;
			out_avail <= out_credits;
			for (int i = 0; i < num_lanes; i++)
			begin
				lane_out[i] <= 0;
			end
		end
		else
		begin
			in_occ <= in_occ + (in_valid ? 1 : 0) - (in_pop ? 1 : 0);
			// Sink grants add, each result spends one
			out_avail <= out_avail + (out_credit ? 1 : 0) - (out_valid ? 1 : 0);
			for (int i = 0; i < num_lanes; i++)
			begin
				lane_out[i] <= lane_out[i] + (lane_valid[i] ? 1 : 0) - (lane_pop[i] ? 1 : 0);
			end
		end
	end

	// A lane is full once it holds lane_depth operations in flight
	always_comb
	begin
		for (int i = 0; i < num_lanes; i++)
		begin
			lane_full[i] = (lane_out[i] >= lane_depth);
		end
	end

	// ----------------------------------------
	// Properties
	// ----------------------------------------
	in_full_a: assert property (@(posedge clk) disable iff (reset)
		in_valid |-> (in_occ < in_depth))
		else $error("in_valid arrived while the input queue was full");

	out_credit_a: assert property (@(posedge clk) disable iff (reset)
		out_valid |-> (out_avail > 0))
		else $error("out_valid fired with no downstream credit left");

	lane_over_a: assert property (@(posedge clk) disable iff (reset)
		(lane_valid & lane_full) == '0)
		else $error("Operation issued to a lane whose result queue is full");

	// Checked from the second reset edge on, when outputs are defined
	reset_out_a: assert property (@(posedge clk)
		(reset && reset_q) |-> !out_valid)
		else $error("out_valid high during reset");

endmodule

bind inc_cluster inc_cluster_asserts asserts_i (
	.clk(clk),
	.reset(reset),
	.in_valid(in_valid),
	.in_pop(in_pop),
	.out_valid(out_valid),
	.out_credit(out_credit),
	.lane_valid(lane_valid),
	.lane_pop(lane_pop)
);

//--- verilog/inc_cluster.sv
/*
  Top level of the INC cluster
  Upstream may send only while it holds a credit, in_depth after reset
  Downstream grants out_credits after reset, one pulse per freed slot
  Results leave in the order operations were accepted
*/
module inc_cluster
	import inc_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic in_valid,
	input inc_op_t in_op,
	output logic in_credit,
	input logic out_credit,
	output logic out_valid,
	output inc_res_t out_res
);

	// Input queue to dispatcher
	inc_op_t in_head;
	logic in_not_empty;
	logic in_pop;

	// Dispatcher to lanes
	logic [num_lanes-1:0] lane_valid;
	inc_op_t lane_op;

	// Lanes to collector, pops return as lane credits
	inc_res_t lane_head [num_lanes];
	logic [num_lanes-1:0] lane_not_empty;
	logic [num_lanes-1:0] lane_pop;

	// ----------------------------------------
	// Input queue
	// ----------------------------------------
	credit_fifo #(
		.payload_t(inc_op_t),
		.depth(in_depth)
	) u_in_fifo (
		.clk(clk),
		.reset(reset),
		.push(in_valid),
		.push_data(in_op),
		.pop(in_pop),
		.head(in_head),
		.not_empty(in_not_empty),
		.credit(in_credit)
	);

	inc_dispatch u_dispatch (
		.clk(clk),
		.reset(reset),
		.head(in_head),
		.not_empty(in_not_empty),
		.pop(in_pop),
		.lane_credit(lane_pop),
		.lane_valid(lane_valid),
		.lane_op(lane_op)
	);

	// ----------------------------------------
	// Lanes
	// ----------------------------------------
	genvar g;
	generate
		for (g = 0; g < num_lanes; g = g + 1)
		begin : g_lane
			inc_lane u_lane (
				.clk(clk),
				.reset(reset),
				.op_valid(lane_valid[g]),
				.op(lane_op),
				.pop(lane_pop[g]),
				.head(lane_head[g]),
				.not_empty(lane_not_empty[g])
			);
		end
	endgenerate

	inc_collect u_collect (
		.clk(clk),
		.reset(reset),
		.lane_head(lane_head),
		.lane_not_empty(lane_not_empty),
		.lane_pop(lane_pop),
		.out_credit(out_credit),
		.out_valid(out_valid),
		.out_res(out_res)
	);

endmodule

//--- verilog/inc_collect.sv
/*
  In-order drain of the lane queues to the registered output
  Pointer order matches the dispatcher, so results keep issue order
  A downstream credit is spent at the pop, out_valid follows a cycle later
  lane_pop doubles as the lane credit back to the dispatcher
*/
module inc_collect
	import inc_pkg::*;
(
	input logic clk,
	input logic reset,
	input inc_res_t lane_head [num_lanes],
	input logic [num_lanes-1:0] lane_not_empty,
	output logic [num_lanes-1:0] lane_pop,
	input logic out_credit,
	output logic out_valid,
	output inc_res_t out_res
);

	// Lane holding the oldest result
	logic [lane_w-1:0] ptr;

	// Downstream credits still free
	logic [out_cnt_w-1:0] cnt;

	// Drain this cycle
	logic fire;

	// ----------------------------------------
	// Drain decision
	// ----------------------------------------
	assign fire = lane_not_empty[ptr] && (cnt != '0);

	always_comb
	begin
		for (int i = 0; i < num_lanes; i++)
		begin
			lane_pop[i] = fire && (ptr == lane_w'(i));
		end
	end

	// ----------------------------------------
	// Pointer and credit counter
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			ptr <= '0;
			cnt <= out_cnt_w'(out_credits);
			out_valid <= 1'b0;
		end
		else
		begin
			if (fire)
			begin
				ptr <= (ptr == lane_w'(num_lanes - 1)) ? '0 : ptr + lane_w'(1);
			end
			// Spend on drain, return on sink pulse
			if (fire && !out_credit)
			begin
				cnt <= cnt - out_cnt_w'(1);
			end
			else if (out_credit && !fire)
			begin
				cnt <= cnt + out_cnt_w'(1);
			end
			out_valid <= fire;
		end
	end

	// ----------------------------------------
	// Output register
	// ----------------------------------------

	// Payload holds between results
	always_ff @(posedge clk)
	begin
		if (fire)
		begin
			out_res <= lane_head[ptr];
		end
	end

endmodule

//--- verilog/inc_dispatch.sv
/*
  Strict round-robin issue from the input queue to the lanes
  Issue waits on the lane at the pointer, other lanes are never tried
  One credit counter per lane, loaded with the lane queue depth
  lane_op is a shared bus qualified by lane_valid
*/
module inc_dispatch
	import inc_pkg::*;
(
	input logic clk,
	input logic reset,
	input inc_op_t head,
	input logic not_empty,
	output logic pop,
	input logic [num_lanes-1:0] lane_credit,
	output logic [num_lanes-1:0] lane_valid,
	output inc_op_t lane_op
);

	// Lane that takes the next operation
	logic [lane_w-1:0] ptr;

	// Free result slots per lane
	logic [lane_cnt_w-1:0] cnt [num_lanes];

	// Issue this cycle
	logic fire;

	// ----------------------------------------
	// Issue decision
	// ----------------------------------------
	assign fire = not_empty && (cnt[ptr] != '0);
	assign pop = fire;
	assign lane_op = head;

	// Only the lane at the pointer sees a valid
	always_comb
	begin
		for (int i = 0; i < num_lanes; i++)
		begin
			lane_valid[i] = fire && (ptr == lane_w'(i));
		end
	end

	// ----------------------------------------
	// Pointer
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			ptr <= '0;
		end
		else if (fire)
		begin
			ptr <= (ptr == lane_w'(num_lanes - 1)) ? '0 : ptr + lane_w'(1);
		end
	end

	// ----------------------------------------
	// Per-lane credit counters
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < num_lanes; i++)
			begin
				cnt[i] <= lane_cnt_w'(lane_depth);
			end
		end
		else
		begin
			// Spend on issue, return on collector pop
			for (int i = 0; i < num_lanes; i++)
			begin
				if (lane_valid[i] && !lane_credit[i])
				begin
					cnt[i] <= cnt[i] - lane_cnt_w'(1);
				end
				else if (lane_credit[i] && !lane_valid[i])
				begin
					cnt[i] <= cnt[i] + lane_cnt_w'(1);
				end
			end
		end
	end

endmodule

//--- verilog/inc_lane.sv
/*
  One INC lane, operation register, sum and flags, result queue
  The lane never refuses work, the dispatcher holds its credits
  A result is pushed one cycle after the operation is registered
  CF is passed through from the operation, INC does not write it
*/
module inc_lane
	import inc_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic op_valid,
	input inc_op_t op,
	input logic pop,
	output inc_res_t head,
	output logic not_empty
);

	// Registered operation and its valid bit
	logic op_vld;
	inc_op_t op_q;

	// Lookahead carries and sum
	logic [data_w-1:0] ones;
	logic [data_w-1:0] sum;

	// Result going into the queue
	inc_res_t res;

	// ----------------------------------------
	// Operation register
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			op_vld <= 1'b0;
		end
		else
		begin
			op_vld <= op_valid;
		end
	end

	// Payload only loads on a valid operation
	always_ff @(posedge clk)
	begin
		if (op_valid)
		begin
			op_q <= op;
		end
	end

	// ----------------------------------------
	// Sum and flags
	// ----------------------------------------
	inc_lookahead u_lookahead (
		.a(op_q.a),
		.all_ones_below(ones)
	);

	// Bit 0 always flips, higher bits flip when all bits below are one
	assign sum = op_q.a ^ {ones[data_w-2:0], 1'b1};

	always_comb
	begin
		res.tag = op_q.tag;
		res.sum = sum;
		// Carry out only when the whole operand is ones
		res.carry_out = ones[data_w-1];
		// Signed overflow only from the largest positive value
		res.flags.of = ones[data_w-2] & ~op_q.a[data_w-1];
		res.flags.sf = sum[data_w-1];
		res.flags.zf = ~|sum;
		// Carry out of the low nibble
		res.flags.af = ones[3];
		// Even parity of the low byte
		res.flags.pf = ~^sum[7:0];
		res.flags.cf = op_q.cf_in;
	end

	// ----------------------------------------
	// Result queue
	// ----------------------------------------

	// Its credit pulse is not needed here, lane pops return credits directly
	credit_fifo #(
		.payload_t(inc_res_t),
		.depth(lane_depth)
	) u_res_fifo (
		.clk(clk),
		.reset(reset),
		.push(op_vld),
		.push_data(res),
		.pop(pop),
		.head(head),
		.not_empty(not_empty),
		.credit()
	);

endmodule

//--- verilog/inc_lookahead.sv
/*
  Carry lookahead for an increment by one
  Parallel-prefix AND tree with Kogge-Stone spans of 1, 2, 4 and so on
  Bit i of the output is the carry out of bit i when adding one
  Pure combinational, depth is log2 of the operand width
*/
module inc_lookahead
	import inc_pkg::*;
(
	input logic [data_w-1:0] a,
	output logic [data_w-1:0] all_ones_below
);

	// Row l holds the AND over a window of 2**l bits ending at each bit
	// Row 0 is the operand itself
	logic [la_levels:0][data_w-1:0] stage;

	assign stage[0] = a;

	// ----------------------------------------
	// Prefix levels
	// ----------------------------------------
	genvar l;
	generate
		for (l = 0; l < la_levels; l = l + 1)
		begin : g_level
			// Each bit combines with the bit one span below it
			// Bits under the span have no partner and pass through
			// so ones are shifted in at the bottom
			assign stage[l+1] = stage[l] &
				{stage[l][data_w-1-(1<<l):0], {(1 << l){1'b1}}};
		end
	endgenerate

	// ----------------------------------------
	// Output
	// ----------------------------------------

	// After the last level every window reaches down to bit 0
	assign all_ones_below = stage[la_levels];

endmodule

//--- verilog/credit_fifo.sv
/*
  Small synchronous FIFO for any packed payload type
  Overflow and underflow are not checked, the credit scheme prevents both
  The credit output pulses one cycle after each pop
  Depth need not be a power of two
*/
module credit_fifo #(
	parameter type payload_t = logic,
	parameter int depth = 2
) (
	input logic clk,
	input logic reset,
	input logic push,
	input payload_t push_data,
	input logic pop,
	output payload_t head,
	output logic not_empty,
	output logic credit
);

	// Pointer and occupancy widths, pointer kept at least one bit wide
	localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
	localparam int cnt_w = $clog2(depth + 1);

	// Storage carries no reset, only the pointers and count do
	payload_t mem [depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;

	// ----------------------------------------
	// Storage write
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		if (push)
		begin
			mem[wr_ptr] <= push_data;
		end
	end

	// ----------------------------------------
	// Pointers, count and credit pulse
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credit <= 1'b0;
		end
		else
		begin
			// Circular wrap at the last entry
			if (push)
			begin
				wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + ptr_w'(1);
			end
			if (pop)
			begin
				rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + ptr_w'(1);
			end
			// Simultaneous push and pop leave the count alone
			if (push && !pop)
			begin
				count <= count + cnt_w'(1);
			end
			else if (pop && !push)
			begin
				count <= count - cnt_w'(1);
			end
			// One credit back per freed entry
			credit <= pop;
		end
	end

	// Head is read straight from storage
	assign head = mem[rd_ptr];
	assign not_empty = (count != '0);

endmodule

//--- verilog/inc_pkg.sv
/*
  Shared widths, depths and payload structs of the increment cluster
  Each queue depth doubles as the initial credit count of its producer
  Credit counter widths are derived from the depths they must hold
*/
package inc_pkg;

	// ----------------------------------------
	// Datapath widths
	// ----------------------------------------

	// Operand and result width
	localparam int data_w = 32;

	// Tag that travels with each operation
	localparam int tag_w = 4;

	// Levels of the prefix AND tree as log2 of the operand width
	localparam int la_levels = $clog2(data_w);

	// ----------------------------------------
	// Lane count, queue depths and credits
	// ----------------------------------------

	localparam int num_lanes = 4;

	// Round-robin pointer width
	localparam int lane_w = $clog2(num_lanes);

	// Input queue depth and the upstream credits after reset
	localparam int in_depth = 4;

	// Result queue depth and initial credits of each lane
	localparam int lane_depth = 2;

	// Downstream credits held by the collector after reset
	localparam int out_credits = 4;

	// Counters must reach the full initial credit value
	localparam int lane_cnt_w = $clog2(lane_depth + 1);
	localparam int out_cnt_w = $clog2(out_credits + 1);

	// ----------------------------------------
	// Payload types
	// ----------------------------------------

	// One INC operation as it enters the cluster
	typedef struct packed {
		logic [tag_w-1:0] tag;
		logic [data_w-1:0] a;
		logic cf_in;
	} inc_op_t;

	// Arithmetic flags written by INC
	typedef struct packed {
		logic of;
		logic sf;
		logic zf;
		logic af;
		logic pf;
		logic cf;
	} inc_flags_t;

	// Finished result of one lane
	typedef struct packed {
		logic [tag_w-1:0] tag;
		logic [data_w-1:0] sum;
		logic carry_out;
		inc_flags_t flags;
	} inc_res_t;

endpackage
